/* src.f */
+incdir+design
design/exec_pkg.sv
design/phys_regfile.sv
design/int_alu_lane.sv
design/mul_lane.sv
design/mem_lane.sv
design/exec_cluster.sv
verification/exec_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execution cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f src.f --top-module exec_cluster_tb -o exec_cluster_sim

./obj_dir/exec_cluster_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* verification/exec_stim.txt */
# lane (0 alu, 1 mul, 2 mem) op src_a src_b dest use_imm imm expected gap, all hex
# gap 0 waits for all earlier results, n issues n cycles after the previous line
0 0 5f 0a 01 0 0000000000000000 0000000000000000 0
0 0 00 00 03 1 0000000000001234 0000000000001234 0
0 0 00 00 04 1 fffffffffffffff0 fffffffffffffff0 0
0 1 03 04 05 0 0000000000000000 0000000000001244 0
0 7 04 03 07 0 0000000000000000 0000000000000001 0
0 5 03 00 08 1 0000000000000044 0000000000012340 0
0 6 04 00 09 1 000000000000003c 000000000000000f 0
1 0 03 05 0a 0 0000000000000000 00000000014c7dd0 0
1 1 04 04 0b 0 0000000000000000 ffffffffffffffe0 1
1 0 04 00 0c 1 0000000000000003 ffffffffffffffd0 1
2 1 03 0b 0d 0 0000000000000010 0000000000000000 0
2 0 04 00 0e 0 0000000000001254 ffffffffffffffe0 1
2 0 07 00 0f 0 0000000000002000 0000000000000000 0
1 0 03 00 10 1 0000000000000002 0000000000002468 0
0 0 00 00 10 1 0000000000000055 0000000000000055 2
0 0 10 00 11 1 0000000000000000 0000000000002468 0

/* verification/exec_cluster_tb.sv */
// Execution cluster testbench
// Replays operations from a stimulus file against a Wishbone memory model
// and checks every completion, with fixed latencies for ALU and multiplier

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_cluster_tb;
	import exec_pkg::*;

	localparam int MAX_OPS = 32;
	localparam int TIMEOUT = 40;

	logic      clock;
	logic      reset;
	issue_t    alu_issue;
	issue_t    mul_issue;
	issue_t    mem_issue;
	logic      mem_ready;
	complete_t alu_done;
	complete_t mul_done;
	complete_t mem_done;
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp = '0;

	// Operation table from the stimulus file
	issue_t             op_tbl [MAX_OPS];
	int                 lane_tbl [MAX_OPS];
	int                 gap_tbl [MAX_OPS];
	logic [`DATA_W-1:0] exp_tbl [MAX_OPS];
	int                 issue_cyc [MAX_OPS];
	bit                 seen [MAX_OPS];
	int                 n_ops;

	logic [`DATA_W-1:0] mem [logic [`DATA_W-1:0]];
	int                 ack_delay;
	int                 cycle = 0;
	int                 mem_idx;
	bit                 mem_taken;
	bit                 hung;
	int                 errors;
	int                 checks;

	exec_cluster exec_cluster_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock)
		cycle++;

	// Wishbone slave that acks after 0 to 4 wait cycles
	always @(negedge clock)
	begin
		if (!wb_req.cyc)
		begin
			wb_rsp.ack = 1'b0;
			ack_delay = $urandom % 5;
		end
		else if (ack_delay > 0)
			ack_delay--;
		else
		begin
			if (wb_req.we)
				mem[wb_req.adr] = wb_req.dat;
			// Unwritten words read 0
			wb_rsp.dat = mem.exists(wb_req.adr) ? mem[wb_req.adr] : '0;
			wb_rsp.ack = 1'b1;
		end
	end

	task automatic value_error(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] want);
		errors++;
		$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
	endtask

	task automatic load_stim();
		int fd;
		int ln, opc, sa, sb, dst, ui, gp;
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] expv;
		string line;
		n_ops = 0;
		fd = $fopen("verification/exec_stim.txt", "r");
		if (fd != 0)
		begin
			void'($fgets(line, fd));
			void'($fgets(line, fd));
			while (n_ops < MAX_OPS && $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
				ln, opc, sa, sb, dst, ui, imm, expv, gp) == 9)
			begin
				op_tbl[n_ops] = '{valid: 1'b1, op: opc[2:0], src_a: sa[6:0], src_b: sb[6:0],
					dest: dst[6:0], use_imm: ui[0], imm: imm};
				lane_tbl[n_ops] = ln;
				exp_tbl[n_ops] = expv;
				gap_tbl[n_ops] = gp;
				issue_cyc[n_ops] = -1;
				n_ops++;
			end
			$fclose(fd);
		end
		assert (n_ops > 0) else
		begin
			errors++;
			$display("Error: no operations read from the stimulus file");
		end
	endtask

	// Match a completion to the oldest outstanding op of its lane
	task automatic check_completion(input complete_t done, input int lane, input string name,
		input int first, input int last, inout int left);
		int k;
		k = first;
		if (done.valid)
		begin
			while (k <= last && (lane_tbl[k] != lane || issue_cyc[k] < 0 || seen[k]))
				k++;
			if (k > last)
			begin
				errors++;
				$display("Error: %s completed with nothing outstanding", name);
			end
			else
			begin
				seen[k] = 1'b1;
				left--;
				checks++;
				assert (done.tag == op_tbl[k].dest)
					else value_error({name, ".tag"}, 64'(done.tag), 64'(op_tbl[k].dest));
				if (lane == 2 && mem_op_e'(op_tbl[k].op[0]) == MEM_STORE)
				begin
					assert (!done.wr_en) else value_error({name, ".wr_en"}, 64'(done.wr_en), 0);
				end
				else
				begin
					assert (done.wr_en) else value_error({name, ".wr_en"}, 64'(done.wr_en), 1);
					assert (done.value == exp_tbl[k])
						else value_error({name, ".value"}, done.value, exp_tbl[k]);
				end
				if (lane != 2)
				begin
					assert (cycle - issue_cyc[k] == (lane == 0 ? 1 : `MUL_STAGES)) else
					begin
						errors++;
						$display("Error: %s came %0d cycles after issue",
							name, cycle - issue_cyc[k]);
					end
				end
			end
		end
	endtask

	task automatic drive_op(input int i);
		case (lane_tbl[i])
			0: alu_issue = op_tbl[i];
			1: mul_issue = op_tbl[i];
			default: mem_issue = op_tbl[i];
		endcase
		if (lane_tbl[i] == 2)
			mem_idx = i;
		else
			issue_cyc[i] = cycle;
	endtask

	// Issue a group on its gaps
	task automatic run_group(input int first, input int last);
		int next;
		int delay;
		int left;
		int waited;
		next = first;
		delay = 0;
		left = last - first + 1;
		waited = 0;
		while (left > 0 && !hung)
		begin
			@(negedge clock);
			waited++;
			check_completion(alu_done, 0, "alu_done", first, last, left);
			check_completion(mul_done, 1, "mul_done", first, last, left);
			check_completion(mem_done, 2, "mem_done", first, last, left);
			if (wb_req.cyc)
			begin
				assert (wb_req.stb) else value_error("wb_req.stb", 64'(wb_req.stb), 1);
			end
			// Lane stays busy through the bus cycle and its completion
			if (wb_req.cyc || mem_done.valid)
			begin
				assert (!mem_ready) else value_error("mem_ready", 64'(mem_ready), 0);
			end
			alu_issue.valid = 1'b0;
			mul_issue.valid = 1'b0;
			if (mem_taken)
				mem_issue.valid = 1'b0;
			if (delay > 0)
				delay--;
			// A held memory issue waits for mem_ready
			if (next <= last && delay == 0 && !(lane_tbl[next] == 2 && mem_issue.valid))
			begin
				drive_op(next);
				next++;
				if (next <= last)
					delay = gap_tbl[next];
			end
			mem_taken = mem_issue.valid && mem_ready;
			if (mem_taken)
				issue_cyc[mem_idx] = cycle;
			if (waited > TIMEOUT)
			begin
				hung = 1'b1;
				errors++;
				$display("Error: results still missing after %0d cycles", TIMEOUT);
			end
		end
	endtask

	initial
	begin
		int first;
		int last;
		void'($urandom(98));
		reset = 1'b1;
		alu_issue = '0;
		mul_issue = '0;
		mem_issue = '0;
		load_stim();
		repeat (5)
		begin
			@(negedge clock);
			assert (!alu_done.valid && !mul_done.valid && !mem_done.valid && !wb_req.cyc) else
			begin
				errors++;
				$display("Error: completion or bus cycle active during reset");
			end
		end
		reset = 1'b0;
		assert (mem_ready) else value_error("mem_ready", 64'(mem_ready), 1);
		first = 0;
		while (first < n_ops && !hung)
		begin
			last = first;
			while (last + 1 < n_ops && gap_tbl[last + 1] != 0)
				last++;
			run_group(first, last);
			first = last + 1;
		end
		$display("Completions checked: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* design/exec_cluster.sv */
// Integer execution cluster
// Register file shared by an ALU lane, a multiplier lane and a
// load/store lane with an external Wishbone port

`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_cluster (
	input  logic                 clock,
	input  logic                 reset,
	input  exec_pkg::issue_t     alu_issue,
	input  exec_pkg::issue_t     mul_issue,
	input  exec_pkg::issue_t     mem_issue,
	output logic                 mem_ready,
	output exec_pkg::complete_t  alu_done,
	output exec_pkg::complete_t  mul_done,
	output exec_pkg::complete_t  mem_done,
	output exec_pkg::wb_req_t    wb_req,
	input  exec_pkg::wb_rsp_t    wb_rsp
);
	import exec_pkg::*;

	logic [`TAG_W-1:0]  alu_rd_a, alu_rd_b;
	logic [`TAG_W-1:0]  mul_rd_a, mul_rd_b;
	logic [`TAG_W-1:0]  mem_rd_a, mem_rd_b;
	logic [`DATA_W-1:0] alu_val_a, alu_val_b;
	logic [`DATA_W-1:0] mul_val_a, mul_val_b;
	logic [`DATA_W-1:0] mem_val_a, mem_val_b;

	phys_regfile phys_regfile_i (
		.clock, .reset,
		.alu_rd_a, .alu_rd_b, .mul_rd_a, .mul_rd_b, .mem_rd_a, .mem_rd_b,
		.alu_wr(alu_done), .mul_wr(mul_done), .mem_wr(mem_done),
		.alu_val_a, .alu_val_b, .mul_val_a, .mul_val_b, .mem_val_a, .mem_val_b
	);

	int_alu_lane int_alu_lane_i (
		.clock, .reset, .issue(alu_issue),
		.rd_a(alu_rd_a), .rd_b(alu_rd_b), .val_a(alu_val_a), .val_b(alu_val_b),
		.result(alu_done)
	);

	mul_lane mul_lane_i (
		.clock, .reset, .issue(mul_issue),
		.rd_a(mul_rd_a), .rd_b(mul_rd_b), .val_a(mul_val_a), .val_b(mul_val_b),
		.result(mul_done)
	);

	mem_lane mem_lane_i (
		.clock, .reset, .issue(mem_issue), .ready(mem_ready),
		.rd_a(mem_rd_a), .rd_b(mem_rd_b), .val_a(mem_val_a), .val_b(mem_val_b),
		.result(mem_done), .wb_req, .wb_rsp
	);

endmodule

/* design/mem_lane.sv */
// Load/store lane
// One 64-bit word per access over a Wishbone classic master port,
// one access outstanding at a time

`timescale 1ns/1ps

`include "exec_consts.svh"

module mem_lane (
	input  logic                 clock,
	input  logic                 reset,
	input  exec_pkg::issue_t     issue,
	output logic                 ready,
	output logic [`TAG_W-1:0]    rd_a,
	output logic [`TAG_W-1:0]    rd_b,
	input  logic [`DATA_W-1:0]   val_a,
	input  logic [`DATA_W-1:0]   val_b,
	output exec_pkg::complete_t  result,
	output exec_pkg::wb_req_t    wb_req,
	input  exec_pkg::wb_rsp_t    wb_rsp
);
	import exec_pkg::*;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_BUS,
		MEM_DONE
	} mem_state_e;

	mem_state_e         state;
	mem_op_e            op_q;
	logic [`DATA_W-1:0] adr_q;
	logic [`DATA_W-1:0] wdata_q;
	logic [`DATA_W-1:0] rdata_q;
	logic [`TAG_W-1:0]  tag_q;
	logic               accept;

	assign rd_a   = issue.src_a;
	assign rd_b   = issue.src_b;
	assign ready  = (state == MEM_IDLE);
	assign accept = issue.valid && ready;

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= MEM_IDLE;
		else
		begin
			case (state)
				MEM_IDLE: if (accept) state <= MEM_BUS;
				MEM_BUS:  if (wb_rsp.ack) state <= MEM_DONE;
				MEM_DONE: state <= MEM_IDLE;
				default:  state <= MEM_IDLE;
			endcase
		end
	end

	// Request fields held stable for the whole bus cycle
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			op_q    <= mem_op_e'(issue.op[0]);
			adr_q   <= val_a + issue.imm;
			wdata_q <= val_b;
			tag_q   <= issue.dest;
		end
		if (state == MEM_BUS && wb_rsp.ack && op_q == MEM_LOAD)
			rdata_q <= wb_rsp.dat;
	end

	assign wb_req = '{cyc: state == MEM_BUS, stb: state == MEM_BUS,
		we: op_q == MEM_STORE, adr: adr_q, dat: wdata_q};

	// Stores complete without a register write
	assign result = '{valid: state == MEM_DONE, wr_en: op_q == MEM_LOAD,
		tag: tag_q, value: rdata_q};

endmodule

/* design/mul_lane.sv */
// Pipelined multiplier lane
// Operand register, full 128-bit product, then low or high half select

`timescale 1ns/1ps

`include "exec_consts.svh"

module mul_lane (
	input  logic                 clock,
	input  logic                 reset,
	input  exec_pkg::issue_t     issue,
	output logic [`TAG_W-1:0]    rd_a,
	output logic [`TAG_W-1:0]    rd_b,
	input  logic [`DATA_W-1:0]   val_a,
	input  logic [`DATA_W-1:0]   val_b,
	output exec_pkg::complete_t  result
);
	import exec_pkg::*;

	// Control that rides along with the data
	typedef struct packed {
		logic              valid;
		logic [`TAG_W-1:0] tag;
		mul_op_e           op;
	} mul_ctl_t;

	mul_ctl_t                ctl_q [`MUL_STAGES];
	logic [`DATA_W-1:0]      a_q;
	logic [`DATA_W-1:0]      b_q;
	logic [2*`DATA_W-1:0]    prod_q;
	logic [`DATA_W-1:0]      res_q;

	assign rd_a = issue.src_a;
	assign rd_b = issue.src_b;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int s = 0; s < `MUL_STAGES; s++)
				ctl_q[s] <= '0;
		end
		else
		begin
			ctl_q[0] <= '{valid: issue.valid, tag: issue.dest, op: mul_op_e'(issue.op[0])};
			for (int s = 1; s < `MUL_STAGES; s++)
				ctl_q[s] <= ctl_q[s-1];
		end
	end

	// Unsigned product, operands widened by the 128-bit target
	always_ff @(posedge clock)
	begin
		a_q    <= val_a;
		b_q    <= issue.use_imm ? issue.imm : val_b;
		prod_q <= a_q * b_q;
		res_q  <= (ctl_q[`MUL_STAGES-2].op == MUL_HU) ? prod_q[2*`DATA_W-1:`DATA_W]
			: prod_q[`DATA_W-1:0];
	end

	assign result = '{valid: ctl_q[`MUL_STAGES-1].valid, wr_en: 1'b1,
		tag: ctl_q[`MUL_STAGES-1].tag, value: res_q};

endmodule

/* design/int_alu_lane.sv */
// Integer ALU lane
// Single-cycle add, sub, logic, shift and signed compare, registered result

`timescale 1ns/1ps

`include "exec_consts.svh"

module int_alu_lane (
	input  logic                 clock,
	input  logic                 reset,
	input  exec_pkg::issue_t     issue,
	output logic [`TAG_W-1:0]    rd_a,
	output logic [`TAG_W-1:0]    rd_b,
	input  logic [`DATA_W-1:0]   val_a,
	input  logic [`DATA_W-1:0]   val_b,
	output exec_pkg::complete_t  result
);
	import exec_pkg::*;

	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] alu_out;
	logic               valid_q;
	logic [`TAG_W-1:0]  tag_q;
	logic [`DATA_W-1:0] value_q;

	assign rd_a = issue.src_a;
	assign rd_b = issue.src_b;
	assign op_b = issue.use_imm ? issue.imm : val_b;

	always_comb
	begin
		case (alu_op_e'(issue.op))
			ALU_ADD: alu_out = val_a + op_b;
			ALU_SUB: alu_out = val_a - op_b;
			ALU_AND: alu_out = val_a & op_b;
			ALU_OR:  alu_out = val_a | op_b;
			ALU_XOR: alu_out = val_a ^ op_b;
			// Shift amount from low 6 bits
			ALU_SLL: alu_out = val_a << op_b[5:0];
			ALU_SRL: alu_out = val_a >> op_b[5:0];
			ALU_SLT: alu_out = {{(`DATA_W-1){1'b0}}, $signed(val_a) < $signed(op_b)};
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= issue.valid;
	end

	always_ff @(posedge clock)
	begin
		tag_q   <= issue.dest;
		value_q <= alu_out;
	end

	assign result = '{valid: valid_q, wr_en: 1'b1, tag: tag_q, value: value_q};

endmodule

/* design/phys_regfile.sv */
// Physical register file
// Six combinational read ports, three prioritized write ports

`timescale 1ns/1ps

`include "exec_consts.svh"

module phys_regfile (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [`TAG_W-1:0]    alu_rd_a,
	input  logic [`TAG_W-1:0]    alu_rd_b,
	input  logic [`TAG_W-1:0]    mul_rd_a,
	input  logic [`TAG_W-1:0]    mul_rd_b,
	input  logic [`TAG_W-1:0]    mem_rd_a,
	input  logic [`TAG_W-1:0]    mem_rd_b,
	input  exec_pkg::complete_t  alu_wr,
	input  exec_pkg::complete_t  mul_wr,
	input  exec_pkg::complete_t  mem_wr,
	output logic [`DATA_W-1:0]   alu_val_a,
	output logic [`DATA_W-1:0]   alu_val_b,
	output logic [`DATA_W-1:0]   mul_val_a,
	output logic [`DATA_W-1:0]   mul_val_b,
	output logic [`DATA_W-1:0]   mem_val_a,
	output logic [`DATA_W-1:0]   mem_val_b
);
	import exec_pkg::*;

	logic [`DATA_W-1:0] regs [`PRF_ENTRIES];

	// Lowest priority first, later ports overwrite
	complete_t wr_port [3];

	assign wr_port[0] = alu_wr;
	assign wr_port[1] = mul_wr;
	assign wr_port[2] = mem_wr;

	// No bypass, a read in the write cycle sees the old value
	assign alu_val_a = regs[alu_rd_a];
	assign alu_val_b = regs[alu_rd_b];
	assign mul_val_a = regs[mul_rd_a];
	assign mul_val_b = regs[mul_rd_b];
	assign mem_val_a = regs[mem_rd_a];
	assign mem_val_b = regs[mem_rd_b];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PRF_ENTRIES; i++)
				regs[i] <= '0;
		end
		else
		begin
			for (int p = 0; p < 3; p++)
				if (wr_port[p].valid && wr_port[p].wr_en)
					regs[wr_port[p].tag] <= wr_port[p].value;
		end
	end

endmodule

/* design/exec_pkg.sv */
// Execution cluster types
// Lane opcodes, issue and completion words, Wishbone request and reply

`include "exec_consts.svh"

package exec_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT
	} alu_op_e;

	// Low half, or high half of the unsigned product
	typedef enum logic {MUL_LO, MUL_HU} mul_op_e;

	typedef enum logic {MEM_LOAD, MEM_STORE} mem_op_e;

	// Op field is decoded by each lane as its own enum
	typedef struct packed {
		logic              valid;
		logic [2:0]        op;
		logic [`TAG_W-1:0] src_a;
		logic [`TAG_W-1:0] src_b;
		logic [`TAG_W-1:0] dest;
		logic              use_imm;
		logic [`DATA_W-1:0] imm;
	} issue_t;

	typedef struct packed {
		logic              valid;
		logic              wr_en;
		logic [`TAG_W-1:0] tag;
		logic [`DATA_W-1:0] value;
	} complete_t;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [`DATA_W-1:0] adr;
		logic [`DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [`DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

/* design/exec_consts.svh */
// Execution cluster sizes
// Register file depth, tag and data widths, multiplier latency

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Physical registers and index width
`define PRF_ENTRIES 96
`define TAG_W 7

// Datapath width
`define DATA_W 64

// Issue to completion latency of the multiplier
`define MUL_STAGES 3

`endif
